// ==== verilog/bank_htu_pkg.sv ====
package bank_htu_pkg;

  // --------------------------------------------------
  // address map
  // --------------------------------------------------
  localparam int ADDR_LSB   = 4;
  localparam int TAG_MSB    = 31;
  localparam int TAG_LSB    = 10;
  localparam int SET_MSB    = 7;
  localparam int SET_LSB    = 5;
  localparam int OFFSET_BIT = 4;

  localparam int N_SETS   = 2 ** (SET_MSB - SET_LSB + 1);
  localparam int MAX_WAYS = 8;

  typedef logic [TAG_MSB-TAG_LSB:0]      tag_t;
  typedef logic [SET_MSB-SET_LSB:0]      set_idx_t;
  typedef logic [$clog2(MAX_WAYS)-1:0]   way_idx_t;
  typedef logic [TAG_MSB-ADDR_LSB:0]     line_addr_t;

  // half-line state
  typedef logic [1:0] half_state_t;
  localparam half_state_t HS_EMPTY = 2'b00;
  localparam half_state_t HS_CLEAN = 2'b01;
  localparam half_state_t HS_DIRTY = 2'b10;

  typedef enum logic [1:0] {
    OP_READ  = 2'b00,
    OP_WRITE = 2'b01,
    OP_FLUSH = 2'b10,
    OP_INVAL = 2'b11
  } htu_op_e;

  // --------------------------------------------------
  // request, per-set result and responses
  // --------------------------------------------------
  typedef struct packed {
    logic [1:0] ch_id;
    htu_op_e    opcode;
    line_addr_t addr;
    logic [7:0] wbuffer_id;
  } htu_req_t;

  typedef struct packed {
    logic        hit;
    logic        need_evict;
    way_idx_t    way;
    half_state_t off0_state;
    half_state_t off1_state;
  } set_result_t;

  // set, way and offset form the 7-bit set/way/offset
  typedef struct packed {
    logic [1:0]  ch_id;
    logic        isu_write;
    logic        need_evict;
    set_idx_t    set;
    way_idx_t    way;
    logic        offset;
    logic [7:0]  wbuffer_id;
    half_state_t off0_state;
    half_state_t off1_state;
  } htu_isu_t;

  typedef struct packed {
    logic     valid;
    set_idx_t set;
    way_idx_t way;
  } linefill_t;

endpackage

// ==== verilog/bank_htu_decode.sv ====
`timescale 1ns/100ps

module bank_htu_decode (
  input  logic                                req_valid_i,
  input  bank_htu_pkg::htu_req_t              req_i,
  input  logic                                allow_in_i,
  output bank_htu_pkg::htu_op_e               op_o,
  output bank_htu_pkg::tag_t                  tag_o,
  output bank_htu_pkg::set_idx_t              set_o,
  output logic                                offset_o,
  output logic [bank_htu_pkg::N_SETS-1:0]     set_en_o
);

  import bank_htu_pkg::*;

  logic xfer;

  // transfer condition, the only place a request counts as accepted
  assign xfer = req_valid_i & allow_in_i;

  assign op_o = req_i.opcode;

  // --------------------------------------------------
  // line address split
  // --------------------------------------------------
  assign tag_o    = req_i.addr[TAG_MSB-ADDR_LSB:TAG_LSB-ADDR_LSB];
  assign set_o    = req_i.addr[SET_MSB-ADDR_LSB:SET_LSB-ADDR_LSB];
  assign offset_o = req_i.addr[OFFSET_BIT-ADDR_LSB];

  // one-hot set decode, qualified by the transfer
  always_comb begin
    set_en_o = '0;
    for (int s = 0; s < N_SETS; s++) begin
      set_en_o[s] = xfer && (set_o == set_idx_t'(s));
    end
  end

endmodule

// ==== verilog/bank_htu_set_entry.sv ====
`timescale 1ns/100ps

module bank_htu_set_entry #(
  parameter int N_WAYS = 8
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      set_en_i,
  input  bank_htu_pkg::htu_op_e     op_i,
  input  bank_htu_pkg::tag_t        tag_i,
  input  logic                      offset_i,
  output bank_htu_pkg::set_result_t result_o
);

  import bank_htu_pkg::*;

  tag_t        tag_q  [N_WAYS];
  half_state_t off0_q [N_WAYS];
  half_state_t off1_q [N_WAYS];
  way_idx_t    rr_ptr_q;
  way_idx_t    rr_ptr_nxt;

  logic [N_WAYS-1:0] hit_vec;
  logic              hit;
  way_idx_t          hit_way;
  way_idx_t          acc_way;
  half_state_t       acc_off0;
  half_state_t       acc_off1;
  logic              acc_dirty;
  logic              alloc;
  logic              upd;
  half_state_t       new_off0;
  half_state_t       new_off1;

  // --------------------------------------------------
  // hit search
  // --------------------------------------------------
  always_comb begin
    for (int w = 0; w < N_WAYS; w++) begin
      hit_vec[w] = (tag_q[w] == tag_i) &&
                   ((off0_q[w] != HS_EMPTY) || (off1_q[w] != HS_EMPTY));
    end
  end

  // lowest hitting way wins
  always_comb begin
    hit_way = '0;
    for (int w = N_WAYS - 1; w >= 0; w--) begin
      if (hit_vec[w]) begin
        hit_way = way_idx_t'(w);
      end
    end
  end

  assign hit      = |hit_vec;
  assign acc_way  = hit ? hit_way : rr_ptr_q;
  assign acc_off0 = off0_q[acc_way];
  assign acc_off1 = off1_q[acc_way];

  assign acc_dirty = (acc_off0 == HS_DIRTY) || (acc_off1 == HS_DIRTY);

  // miss on read/write replaces the victim
  assign alloc = set_en_i && !hit && ((op_i == OP_READ) || (op_i == OP_WRITE));

  assign rr_ptr_nxt = (rr_ptr_q == way_idx_t'(N_WAYS - 1)) ? '0 : rr_ptr_q + 1'b1;

  always_comb begin
    result_o.hit        = hit;
    result_o.need_evict = acc_dirty &&
                          ((((op_i == OP_READ) || (op_i == OP_WRITE)) && !hit) ||
                           ((op_i == OP_FLUSH) && hit));
    result_o.way        = acc_way;
    result_o.off0_state = acc_off0;
    result_o.off1_state = acc_off1;
  end

  // --------------------------------------------------
  // next state of the accessed way
  // --------------------------------------------------
  always_comb begin
    upd      = 1'b0;
    new_off0 = acc_off0;
    new_off1 = acc_off1;
    case (op_i)
      OP_READ: begin
        if (!hit) begin
          upd      = 1'b1;
          new_off0 = offset_i ? HS_EMPTY : HS_CLEAN;
          new_off1 = offset_i ? HS_CLEAN : HS_EMPTY;
        end
      end
      OP_WRITE: begin
        upd = 1'b1;
        if (!hit) begin
          new_off0 = HS_EMPTY;
          new_off1 = HS_EMPTY;
        end
        if (offset_i) begin
          new_off1 = HS_DIRTY;
        end else begin
          new_off0 = HS_DIRTY;
        end
      end
      OP_FLUSH: begin
        if (hit) begin
          upd = 1'b1;
          if (acc_off0 == HS_DIRTY) begin
            new_off0 = HS_CLEAN;
          end
          if (acc_off1 == HS_DIRTY) begin
            new_off1 = HS_CLEAN;
          end
        end
      end
      OP_INVAL: begin
        if (hit) begin
          upd      = 1'b1;
          new_off0 = HS_EMPTY;
          new_off1 = HS_EMPTY;
        end
      end
      default: begin
        upd = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (alloc) begin
      tag_q[rr_ptr_q] <= tag_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int w = 0; w < N_WAYS; w++) begin
        off0_q[w] <= HS_EMPTY;
        off1_q[w] <= HS_EMPTY;
      end
      rr_ptr_q <= '0;
    end else if (set_en_i) begin
      if (upd) begin
        off0_q[acc_way] <= new_off0;
        off1_q[acc_way] <= new_off1;
      end
      if (alloc) begin
        rr_ptr_q <= rr_ptr_nxt;
      end
    end
  end

endmodule

// ==== verilog/bank_htu_resp_mux.sv ====
`timescale 1ns/100ps

module bank_htu_resp_mux (
  input  logic                      req_valid_i,
  input  bank_htu_pkg::htu_req_t    req_i,
  input  bank_htu_pkg::set_idx_t    set_i,
  input  logic                      offset_i,
  input  bank_htu_pkg::set_result_t results_i [bank_htu_pkg::N_SETS],
  output bank_htu_pkg::htu_isu_t    isu_o,
  output bank_htu_pkg::linefill_t   linefill_o
);

  import bank_htu_pkg::*;

  set_result_t sel;
  half_state_t acc_state;
  logic        is_read;

  // --------------------------------------------------
  // addressed set
  // --------------------------------------------------
  assign sel       = results_i[set_i];
  assign acc_state = offset_i ? sel.off1_state : sel.off0_state;
  assign is_read   = (req_i.opcode == OP_READ);

  // miss, or hit on a line whose accessed half is empty
  always_comb begin
    linefill_o.valid = req_valid_i && is_read &&
                       (!sel.hit || (acc_state == HS_EMPTY));
    linefill_o.set   = set_i;
    linefill_o.way   = sel.way;
  end

  // --------------------------------------------------
  // issue unit response
  // --------------------------------------------------
  always_comb begin
    isu_o.ch_id      = req_i.ch_id;
    isu_o.isu_write  = (req_i.opcode == OP_WRITE);
    isu_o.need_evict = sel.need_evict;
    isu_o.set        = set_i;
    isu_o.way        = sel.way;
    isu_o.offset     = offset_i;
    isu_o.wbuffer_id = req_i.wbuffer_id;
    isu_o.off0_state = sel.off0_state;
    isu_o.off1_state = sel.off1_state;
  end

endmodule

// ==== verilog/bank_htu.sv ====
`timescale 1ns/100ps

module bank_htu #(
  parameter int N_WAYS = 8
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // crossbar
  input  logic                    req_valid_i,
  output logic                    req_allow_in_o,
  input  bank_htu_pkg::htu_req_t  req_i,
  // issue unit
  output logic                    isu_valid_o,
  input  logic                    isu_allow_in_i,
  output bank_htu_pkg::htu_isu_t  isu_o,
  output bank_htu_pkg::linefill_t linefill_o
);

  import bank_htu_pkg::*;

  htu_op_e           op;
  tag_t              tag;
  set_idx_t          set_idx;
  logic              offset;
  logic [N_SETS-1:0] set_en;
  set_result_t       results [N_SETS];

  assign req_allow_in_o = isu_allow_in_i;
  assign isu_valid_o    = req_valid_i;

  bank_htu_decode u_decode (
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .allow_in_i  (isu_allow_in_i),
    .op_o        (op),
    .tag_o       (tag),
    .set_o       (set_idx),
    .offset_o    (offset),
    .set_en_o    (set_en)
  );

  // --------------------------------------------------
  // set array
  // --------------------------------------------------
  for (genvar g = 0; g < N_SETS; g++) begin : g_set
    bank_htu_set_entry #(
      .N_WAYS (N_WAYS)
    ) u_set_entry (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .set_en_i (set_en[g]),
      .op_i     (op),
      .tag_i    (tag),
      .offset_i (offset),
      .result_o (results[g])
    );
  end

  bank_htu_resp_mux u_resp_mux (
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .set_i       (set_idx),
    .offset_i    (offset),
    .results_i   (results),
    .isu_o       (isu_o),
    .linefill_o  (linefill_o)
  );

endmodule

// ==== dv/tb_bank_htu.sv ====
`timescale 1ns/100ps

module tb_bank_htu;

  import bank_htu_pkg::*;

  localparam int NW       = 8;
  localparam int RST_WAIT = 20;

  typedef struct packed {
    htu_op_e    op;
    set_idx_t   set;
    logic [3:0] tsel;
    logic       off;
    logic       allow;
    logic       wr;
    logic       ev;
    way_idx_t   way;
    logic       lf;
  } step_t;

  logic      clk_i;
  logic      rst_n_i;
  logic      req_valid_i;
  htu_req_t  req_i;
  logic      isu_allow_in_i;
  logic      req_allow_in_o;
  logic      isu_valid_o;
  htu_isu_t  isu_o;
  linefill_t linefill_o;

  step_t       steps [$];
  tag_t        tag_pool [16];
  logic [31:0] rng_state;

  // reference model of the tag store
  tag_t        m_tag  [N_SETS][NW];
  half_state_t m_half [N_SETS][NW][2];
  int          m_ptr  [N_SETS];

  bank_htu #(
    .N_WAYS (NW)
  ) uut (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_valid_i    (req_valid_i),
    .req_allow_in_o (req_allow_in_o),
    .req_i          (req_i),
    .isu_valid_o    (isu_valid_o),
    .isu_allow_in_i (isu_allow_in_i),
    .isu_o          (isu_o),
    .linefill_o     (linefill_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic add_step(input htu_op_e op, input int set, input int tsel, input int off,
                          input int allow, input int wr, input int ev, input int way,
                          input int lf);
    step_t s;
    s.op    = op;
    s.set   = set_idx_t'(set);
    s.tsel  = 4'(tsel);
    s.off   = off[0];
    s.allow = allow[0];
    s.wr    = wr[0];
    s.ev    = ev[0];
    s.way   = way_idx_t'(way);
    s.lf    = lf[0];
    steps.push_back(s);
  endtask

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  task automatic model_lookup(input int s, input tag_t t, output logic hit, output int way);
    hit = 1'b0;
    way = m_ptr[s];
    // lowest hitting way wins
    for (int w = NW - 1; w >= 0; w--) begin
      if (m_tag[s][w] == t &&
          (m_half[s][w][0] != HS_EMPTY || m_half[s][w][1] != HS_EMPTY)) begin
        hit = 1'b1;
        way = w;
      end
    end
  endtask

  task automatic model_update(input htu_op_e op, input int s, input tag_t t, input int off,
                              input logic hit, input int way);
    if (!hit && (op == OP_READ || op == OP_WRITE)) begin
      m_tag[s][way]     = t;
      m_half[s][way][0] = HS_EMPTY;
      m_half[s][way][1] = HS_EMPTY;
      if (op == OP_READ) begin
        m_half[s][way][off] = HS_CLEAN;
      end
      m_ptr[s] = (m_ptr[s] + 1) % NW;
    end
    case (op)
      OP_WRITE: begin
        m_half[s][way][off] = HS_DIRTY;
      end
      OP_FLUSH: begin
        for (int h = 0; h < 2; h++) begin
          if (hit && m_half[s][way][h] == HS_DIRTY) begin
            m_half[s][way][h] = HS_CLEAN;
          end
        end
      end
      OP_INVAL: begin
        if (hit) begin
          m_half[s][way][0] = HS_EMPTY;
          m_half[s][way][1] = HS_EMPTY;
        end
      end
      default: begin
      end
    endcase
  endtask

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------
  task automatic check_isu(input htu_isu_t got, input htu_isu_t exp, input int idx);
    if (got !== exp) begin
      $display("FAILED at %0t: step %0d isu_o is %h, expected %h", $time, idx, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "issue unit response mismatch");
    end
  endtask

  task automatic check_linefill(input linefill_t got, input linefill_t exp, input int idx);
    if (got !== exp) begin
      $display("FAILED at %0t: step %0d linefill_o is %h, expected %h",
               $time, idx, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "linefill request mismatch");
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what,
                            input int idx);
    if (got !== exp) begin
      $display("FAILED at %0t: step %0d %s is %b, expected %b", $time, idx, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "handshake mismatch");
    end
  endtask

  initial begin
    step_t     st;
    tag_t      t;
    logic      m_hit;
    int        m_way;
    logic      m_dirty;
    logic      m_ev;
    logic      m_lf;
    htu_isu_t  exp_isu;
    linefill_t exp_lf;
    int        cnt;

    rst_n_i        = 1'b0;
    req_valid_i    = 1'b0;
    req_i          = '0;
    isu_allow_in_i = 1'b0;
    rng_state      = 32'd30183;

    // low four bits keep every tag distinct
    for (int i = 0; i < 16; i++) begin
      if (i < 4) begin
        tag_pool[i] = {18'h20c40 + 18'(i), 4'(i)};
      end else begin
        rng_state   = xorshift32(rng_state);
        tag_pool[i] = {rng_state[21:4], 4'(i)};
      end
    end
    for (int s = 0; s < N_SETS; s++) begin
      m_ptr[s] = 0;
      for (int w = 0; w < NW; w++) begin
        m_tag[s][w]     = '0;
        m_half[s][w][0] = HS_EMPTY;
        m_half[s][w][1] = HS_EMPTY;
      end
    end

    // op, set, tag, off, allow | isu_write, need_evict, way, linefill
    add_step(OP_READ,  0, 0, 0, 1, 0, 0, 0, 1);
    add_step(OP_READ,  0, 0, 0, 1, 0, 0, 0, 0);
    add_step(OP_READ,  3, 1, 1, 1, 0, 0, 0, 1);
    add_step(OP_READ,  0, 0, 1, 1, 0, 0, 0, 1);
    add_step(OP_WRITE, 0, 0, 1, 1, 1, 0, 0, 0);
    add_step(OP_READ,  0, 0, 1, 1, 0, 0, 0, 0);
    // nine tags into set 1 and the last one evicts way 0
    for (int k = 0; k < 9; k++) begin
      add_step(OP_WRITE, 1, 4 + k, 0, 1, 1, (k == 8) ? 1 : 0, k % NW, 0);
    end
    add_step(OP_FLUSH, 1, 12, 0, 1, 0, 1, 0, 0);
    add_step(OP_READ,  1, 12, 0, 1, 0, 0, 0, 0);
    add_step(OP_FLUSH, 1, 13, 0, 1, 0, 0, 1, 0);
    add_step(OP_READ,  1, 5, 0, 1, 0, 0, 1, 0);
    add_step(OP_INVAL, 3, 1, 1, 1, 0, 0, 0, 0);
    add_step(OP_READ,  0, 0, 1, 1, 0, 0, 0, 0);
    add_step(OP_READ,  3, 1, 1, 1, 0, 0, 1, 1);
    // back-pressure
    add_step(OP_READ,  4, 2, 0, 0, 0, 0, 0, 1);
    add_step(OP_READ,  4, 2, 0, 0, 0, 0, 0, 1);
    add_step(OP_READ,  4, 2, 0, 1, 0, 0, 0, 1);
    add_step(OP_READ,  4, 2, 0, 1, 0, 0, 0, 0);
    add_step(OP_WRITE, 1, 5, 1, 0, 1, 0, 1, 0);
    add_step(OP_READ,  1, 5, 1, 1, 0, 0, 1, 1);

    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    cnt     = 0;
    while (isu_o.off0_state !== HS_EMPTY || isu_o.off1_state !== HS_EMPTY ||
           linefill_o.valid !== 1'b0) begin
      if (cnt == RST_WAIT) begin
        $display("timeout: tag store did not reach its empty state after reset");
        $display("Simulation FAILED");
        $fatal(1, "reset timeout");
      end
      @(posedge clk_i);
      #1;
      cnt++;
    end

    // --------------------------------------------------
    // table loop with one request per cycle
    // --------------------------------------------------
    for (int i = 0; i < steps.size(); i++) begin
      st = steps[i];
      t  = tag_pool[st.tsel];
      @(posedge clk_i);
      #1;
      rng_state        = xorshift32(rng_state);
      req_valid_i      = 1'b1;
      isu_allow_in_i   = st.allow;
      req_i.ch_id      = 2'(i);
      req_i.opcode     = st.op;
      req_i.addr       = {t, rng_state[1:0], st.set, st.off};
      req_i.wbuffer_id = rng_state[15:8];

      model_lookup(int'(st.set), t, m_hit, m_way);
      m_dirty = (m_half[st.set][m_way][0] == HS_DIRTY) ||
                (m_half[st.set][m_way][1] == HS_DIRTY);
      m_ev    = m_dirty && ((((st.op == OP_READ) || (st.op == OP_WRITE)) && !m_hit) ||
                            ((st.op == OP_FLUSH) && m_hit));
      m_lf    = (st.op == OP_READ) &&
                (!m_hit || m_half[st.set][m_way][st.off] == HS_EMPTY);
      if (m_way != int'(st.way) || m_ev != st.ev || m_lf != st.lf) begin
        $display("reference model disagrees with the stimulus table at step %0d", i);
        $display("Simulation FAILED");
        $fatal(1, "inconsistent stimulus table");
      end

      exp_isu.ch_id      = 2'(i);
      exp_isu.isu_write  = st.wr;
      exp_isu.need_evict = st.ev;
      exp_isu.set        = st.set;
      exp_isu.way        = st.way;
      exp_isu.offset     = st.off;
      exp_isu.wbuffer_id = rng_state[15:8];
      exp_isu.off0_state = m_half[st.set][m_way][0];
      exp_isu.off1_state = m_half[st.set][m_way][1];
      exp_lf.valid       = st.lf;
      exp_lf.set         = st.set;
      exp_lf.way         = st.way;

      // sample just before the edge
      #8;
      check_flag(req_allow_in_o, st.allow, "req_allow_in_o", i);
      check_flag(isu_valid_o, 1'b1, "isu_valid_o", i);
      check_isu(isu_o, exp_isu, i);
      check_linefill(linefill_o, exp_lf, i);
      if (st.allow) begin
        model_update(st.op, int'(st.set), t, int'(st.off), m_hit, m_way);
      end
    end

    @(posedge clk_i);
    #1;
    req_valid_i    = 1'b0;
    isu_allow_in_i = 1'b0;
    // idle cycle, the last read still misses its half
    #8;
    check_flag(isu_valid_o, 1'b0, "isu_valid_o", steps.size());
    check_flag(linefill_o.valid, 1'b0, "linefill_o.valid", steps.size());
    check_flag(req_allow_in_o, 1'b0, "req_allow_in_o", steps.size());
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== compile.f ====
verilog/bank_htu_pkg.sv
verilog/bank_htu_decode.sv
verilog/bank_htu_set_entry.sv
verilog/bank_htu_resp_mux.sv
verilog/bank_htu.sv
dv/tb_bank_htu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_bank_htu
FLIST     ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR)
